// File: tb/wr_patterns.txt
# base_addr(hex) length_bytes(dec) tdest(hex) tuser(hex) mem_stall(0/1) desc_stall(0/1)
# One packet per line, each in its own address range
0100 64 01 0 0 0
0200 8 02 1 0 0
0303 13 03 2 0 0
0405 20 04 3 0 0
0507 1 05 0 0 0
0601 7 06 1 0 0
0706 31 07 2 1 0
0802 45 08 3 1 0
0903 16 09 0 0 1
0a05 12 0a 1 0 1
0b00 24 0b 2 1 1
0c07 9 0c 3 1 1

// File: sources.f
logic/dma_pkg.sv
logic/wr_beat_if.sv
logic/wr_realign.sv
logic/wr_addr_count.sv
logic/recv_desc_reg.sv
logic/axis_wr_dma.sv
tb/axis_wr_dma_chk.sv
tb/axis_wr_dma_tb.sv

// File: Bender.yml
package:
  name: axis_wr_dma

sources:
  - logic/dma_pkg.sv
  - logic/wr_beat_if.sv
  - logic/wr_realign.sv
  - logic/wr_addr_count.sv
  - logic/recv_desc_reg.sv
  - logic/axis_wr_dma.sv
  - target: test
    files:
      - tb/axis_wr_dma_chk.sv
      - tb/axis_wr_dma_tb.sv

// File: tb/axis_wr_dma_tb.sv
module axis_wr_dma_tb;

  import dma_pkg::*;

  localparam int DATA_WIDTH = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int MASK_BITS  = $clog2(STRB_WIDTH);
  localparam int MAX_PKTS   = 32;
  localparam int DESC_HOLD  = 20;

  logic                  clk;
  logic                  rst;
  logic [DATA_WIDTH-1:0] s_axis_tdata;
  logic [STRB_WIDTH-1:0] s_axis_tkeep;
  logic                  s_axis_tvalid;
  logic                  s_axis_tready;
  logic                  s_axis_tlast;
  dest_t                 s_axis_tdest;
  user_t                 s_axis_tuser;
  addr_t                 wr_base_addr;
  logic                  mem_wr_en;
  logic [STRB_WIDTH-1:0] mem_wr_strb;
  addr_t                 mem_wr_addr;
  logic [DATA_WIDTH-1:0] mem_wr_data;
  logic                  mem_wr_last;
  logic                  mem_wr_ready;
  logic                  recv_desc_valid;
  logic                  recv_desc_ready;
  addr_t                 recv_desc_addr;
  len_t                  recv_desc_len;
  dest_t                 recv_desc_tdest;
  user_t                 recv_desc_tuser;

  ////////////////////////////////////////////////////
  // Pattern table, expectations and memory images
  ////////////////////////////////////////////////////

  addr_t      pat_base [MAX_PKTS];
  int         pat_len  [MAX_PKTS];
  dest_t      pat_dest [MAX_PKTS];
  user_t      pat_user [MAX_PKTS];
  bit         pat_mem  [MAX_PKTS];
  bit         pat_desc [MAX_PKTS];
  int         pat_off  [MAX_PKTS];
  logic [7:0] pkt_bytes [$];
  logic [7:0] mem     [65536];
  logic [7:0] exp_mem [65536];
  addr_t      exp_addr_q [$];
  len_t       exp_len_q  [$];
  dest_t      exp_dest_q [$];
  user_t      exp_user_q [$];
  int         beats_q    [$];

  integer      seed = 80;
  int          n_pat = 0;
  int          total_beats = 0;
  int          errors = 0;
  int          total_errors;
  int          desc_done = 0;
  int          beat_cnt = 0;
  int          last_cnt = 0;
  int          pkt_started = 0;
  int          pkt_seen = 0;
  int          desc_hold = 0;
  bit          loaded = 1'b0;
  logic        mem_stall_on = 1'b0;
  logic [31:0] rnd;
  addr_t       byte_addr;

  axis_wr_dma #(.DATA_WIDTH(DATA_WIDTH)) dut (.*);

  bind axis_wr_dma axis_wr_dma_chk #(.DATA_WIDTH(DATA_WIDTH)) u_chk (
    .clk(clk), .rst(rst), .mem_wr_en(mem_wr_en), .mem_wr_ready(mem_wr_ready),
    .mem_wr_last(mem_wr_last), .mem_wr_strb(mem_wr_strb), .mem_wr_addr(mem_wr_addr),
    .recv_desc_valid(recv_desc_valid), .recv_desc_ready(recv_desc_ready),
    .recv_desc_addr(recv_desc_addr), .recv_desc_len(recv_desc_len),
    .recv_desc_tdest(recv_desc_tdest), .recv_desc_tuser(recv_desc_tuser)
  );

  always #20 clk = ~clk;

  // Untouched memory holds a value tied to every address bit
  function automatic logic [7:0] fill_byte(input addr_t a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
  endtask

  // Reads every packet line and draws its payload up front
  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    logic [15:0] base;
    int          len;
    logic [7:0]  dest;
    logic [1:0]  user;
    int          ms;
    int          ds;
    logic [31:0] r;
    fd = $fopen("tb/wr_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open tb/wr_patterns.txt, no packets were sent");
      return;
    end
    while (!$feof(fd) && n_pat < MAX_PKTS) begin
      line = "";
      void'($fgets(line, fd));
      // Comment and blank lines do not scan as six fields
      n = $sscanf(line, "%h %d %h %h %d %d", base, len, dest, user, ms, ds);
      if (n == 6) begin
        pat_base[n_pat] = base;
        pat_len[n_pat]  = len;
        pat_dest[n_pat] = dest;
        pat_user[n_pat] = user;
        pat_mem[n_pat]  = (ms != 0);
        pat_desc[n_pat] = (ds != 0);
        pat_off[n_pat]  = pkt_bytes.size();
        for (int i = 0; i < len; i++) begin
          r = $random(seed);
          pkt_bytes.push_back(r[7:0]);
          exp_mem[addr_t'(base + i)] = r[7:0];
        end
        exp_addr_q.push_back(base);
        exp_len_q.push_back(len_t'(len));
        exp_dest_q.push_back(dest);
        exp_user_q.push_back(user);
        // Memory words touched from the word holding the base byte
        beats_q.push_back((int'(base[MASK_BITS-1:0]) + len + STRB_WIDTH - 1) / STRB_WIDTH);
        total_beats += beats_q[$];
        n_pat++;
      end
    end
    $fclose(fd);
  endtask

  // Presents one packet word by word and waits for each to be accepted
  task automatic send_packet(input int k);
    int words;
    int nbytes;
    words = (pat_len[k] + STRB_WIDTH - 1) / STRB_WIDTH;
    for (int w = 0; w < words; w++) begin
      @(negedge clk);
      if (w == 0) begin
        pkt_started <= pkt_started + 1;
      end
      nbytes = pat_len[k] - w * STRB_WIDTH;
      s_axis_tdata = '0;
      s_axis_tkeep = '0;
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (i < nbytes) begin
          s_axis_tdata[8*i +: 8] = pkt_bytes[pat_off[k] + w * STRB_WIDTH + i];
          s_axis_tkeep[i] = 1'b1;
        end
      end
      s_axis_tvalid = 1'b1;
      s_axis_tlast  = (w == words - 1);
      // Only the first word carries the packet's tags and base address
      if (w == 0) begin
        s_axis_tdest = pat_dest[k];
        s_axis_tuser = pat_user[k];
        wr_base_addr = pat_base[k];
      end else begin
        s_axis_tdest = ~pat_dest[k];
        s_axis_tuser = ~pat_user[k];
        wr_base_addr = ~pat_base[k];
      end
      @(posedge clk);
      while (!s_axis_tready) begin
        @(posedge clk);
      end
    end
  endtask

  ////////////////////////////////////////////////////
  // Back-pressure on the memory port and descriptor
  ////////////////////////////////////////////////////

  always @(negedge clk) begin
    rnd = $random(seed);
    // Stall modes follow the packet that has just started
    if (pkt_started != pkt_seen) begin
      pkt_seen = pkt_started;
      mem_stall_on = pat_mem[pkt_seen - 1];
      if (pat_desc[pkt_seen - 1]) begin
        desc_hold = DESC_HOLD;
      end
    end
    mem_wr_ready    = !(mem_stall_on && rnd[1:0] == 2'b00);
    recv_desc_ready = (desc_hold == 0);
    if (desc_hold > 0) begin
      desc_hold--;
    end
  end

  ////////////////////////////////////////////////////
  // Memory model and descriptor monitor
  ////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst && mem_wr_en && mem_wr_ready) begin
      if (mem_wr_addr[MASK_BITS-1:0] !== '0) begin
        errors++;
        $display("Memory beat at address 0x%0h is not word aligned", mem_wr_addr);
      end
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (mem_wr_strb[i]) begin
          byte_addr = mem_wr_addr + addr_t'(i);
          mem[byte_addr] = mem_wr_data[8*i +: 8];
        end
      end
      beat_cnt++;
      if (mem_wr_last) begin
        if (beats_q.size() == 0) begin
          errors++;
          $display("A last memory beat arrived with no packet outstanding");
        end else begin
          if (beat_cnt != beats_q[0]) begin
            report_mismatch($sformatf("beats pkt %0d", last_cnt), beats_q[0], beat_cnt);
          end
          void'(beats_q.pop_front());
        end
        beat_cnt = 0;
        last_cnt++;
      end
    end
    if (!rst && recv_desc_valid && recv_desc_ready) begin
      if (exp_addr_q.size() == 0) begin
        errors++;
        $display("A descriptor arrived with no packet left to describe");
      end else begin
        if (recv_desc_addr !== exp_addr_q[0]) begin
          report_mismatch($sformatf("desc_addr pkt %0d", desc_done), exp_addr_q[0],
                          recv_desc_addr);
        end
        if (recv_desc_len !== exp_len_q[0]) begin
          report_mismatch($sformatf("desc_len pkt %0d", desc_done), exp_len_q[0],
                          recv_desc_len);
        end
        if (recv_desc_tdest !== exp_dest_q[0]) begin
          report_mismatch($sformatf("desc_tdest pkt %0d", desc_done), exp_dest_q[0],
                          recv_desc_tdest);
        end
        if (recv_desc_tuser !== exp_user_q[0]) begin
          report_mismatch($sformatf("desc_tuser pkt %0d", desc_done), exp_user_q[0],
                          recv_desc_tuser);
        end
        void'(exp_addr_q.pop_front());
        void'(exp_len_q.pop_front());
        void'(exp_dest_q.pop_front());
        void'(exp_user_q.pop_front());
      end
      desc_done++;
    end
  end

  // Budget of four cycles per memory word plus a fixed margin
  initial begin
    wait (loaded);
    repeat (4 * total_beats + 200) @(posedge clk);
    $display("Timeout after %0d cycles, %0d of %0d descriptors received",
             4 * total_beats + 200, desc_done, n_pat);
    $display("Checks failed");
    $finish;
  end

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    s_axis_tdata    = '0;
    s_axis_tkeep    = '0;
    s_axis_tvalid   = 1'b0;
    s_axis_tlast    = 1'b0;
    s_axis_tdest    = '0;
    s_axis_tuser    = '0;
    wr_base_addr    = '0;
    mem_wr_ready    = 1'b1;
    recv_desc_ready = 1'b1;
    for (int a = 0; a < 65536; a++) begin
      mem[a]     = fill_byte(addr_t'(a));
      exp_mem[a] = mem[a];
    end
    load_patterns();
    loaded = 1'b1;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Outputs stay idle before any input arrives
    @(posedge clk);
    if (mem_wr_en !== 1'b0) begin
      report_mismatch("reset mem_wr_en", 0, mem_wr_en);
    end
    if (mem_wr_last !== 1'b0) begin
      report_mismatch("reset mem_wr_last", 0, mem_wr_last);
    end
    if (recv_desc_valid !== 1'b0) begin
      report_mismatch("reset recv_desc_valid", 0, recv_desc_valid);
    end

    for (int k = 0; k < n_pat; k++) begin
      send_packet(k);
    end
    @(negedge clk);
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;

    while (desc_done < n_pat) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (beats_q.size() != 0) begin
      errors++;
      $display("%0d packets never saw a last memory beat", beats_q.size());
    end
    for (int a = 0; a < 65536; a++) begin
      if (mem[a] !== exp_mem[a]) begin
        report_mismatch($sformatf("mem byte 0x%04h", a), exp_mem[a], mem[a]);
      end
    end

    total_errors = errors + dut.u_chk.fail_count;
    $display("Error count: %0d testbench, %0d assertion", errors, dut.u_chk.fail_count);
    if (total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb/axis_wr_dma_chk.sv
module axis_wr_dma_chk #(
  parameter int DATA_WIDTH = 64
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    mem_wr_en,
  input  logic                    mem_wr_ready,
  input  logic                    mem_wr_last,
  input  logic [DATA_WIDTH/8-1:0] mem_wr_strb,
  input  dma_pkg::addr_t          mem_wr_addr,
  input  logic                    recv_desc_valid,
  input  logic                    recv_desc_ready,
  input  dma_pkg::addr_t          recv_desc_addr,
  input  dma_pkg::len_t           recv_desc_len,
  input  dma_pkg::dest_t          recv_desc_tdest,
  input  dma_pkg::user_t          recv_desc_tuser
);

  // Number of assertion failures, read by the testbench at the end
  int fail_count = 0;

  // A stalled write beat keeps its address, strobes and last flag
  wr_hold: assert property (@(posedge clk) disable iff (rst)
    mem_wr_en && !mem_wr_ready |=> mem_wr_en && $stable(mem_wr_addr) &&
      $stable(mem_wr_strb) && $stable(mem_wr_last))
    else begin
      fail_count++;
      $error("memory write beat changed while mem_wr_ready was low");
    end

  // The descriptor stays valid and unchanged until it is taken
  desc_hold: assert property (@(posedge clk) disable iff (rst)
    recv_desc_valid && !recv_desc_ready |=> recv_desc_valid &&
      $stable(recv_desc_addr) && $stable(recv_desc_len) &&
      $stable(recv_desc_tdest) && $stable(recv_desc_tuser))
    else begin
      fail_count++;
      $error("receive descriptor dropped or changed before recv_desc_ready");
    end

  // Synchronous reset clears both outputs on the following cycle
  reset_idle: assert property (@(posedge clk)
    rst |=> !mem_wr_en && !recv_desc_valid)
    else begin
      fail_count++;
      $error("mem_wr_en or recv_desc_valid high right after reset");
    end

endmodule

// File: logic/axis_wr_dma.sv
module axis_wr_dma #(
  parameter int DATA_WIDTH = 64
) (
  input  logic                    clk,
  input  logic                    rst,

  // Incoming packet stream
  input  logic [DATA_WIDTH-1:0]   s_axis_tdata,
  input  logic [DATA_WIDTH/8-1:0] s_axis_tkeep,
  input  logic                    s_axis_tvalid,
  output logic                    s_axis_tready,
  input  logic                    s_axis_tlast,
  input  dma_pkg::dest_t          s_axis_tdest,
  input  dma_pkg::user_t          s_axis_tuser,
  input  dma_pkg::addr_t          wr_base_addr,

  // Memory write port
  output logic                    mem_wr_en,
  output logic [DATA_WIDTH/8-1:0] mem_wr_strb,
  output dma_pkg::addr_t          mem_wr_addr,
  output logic [DATA_WIDTH-1:0]   mem_wr_data,
  output logic                    mem_wr_last,
  input  logic                    mem_wr_ready,

  // Receive descriptor
  output logic                    recv_desc_valid,
  input  logic                    recv_desc_ready,
  output dma_pkg::addr_t          recv_desc_addr,
  output dma_pkg::len_t           recv_desc_len,
  output dma_pkg::dest_t          recv_desc_tdest,
  output dma_pkg::user_t          recv_desc_tuser
);

  import dma_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int MASK_BITS  = $clog2(STRB_WIDTH);

  logic  start;
  logic  desc_block;
  addr_t start_addr;
  len_t  next_len;

  wr_beat_if #(.STRB_WIDTH(STRB_WIDTH)) beat_bus ();

  // Memory back-pressure reaches every block through the beat bus
  assign beat_bus.ready = mem_wr_ready;
  assign mem_wr_en      = beat_bus.en;
  assign mem_wr_strb    = beat_bus.strb;
  assign mem_wr_last    = beat_bus.last;

  wr_realign #(.DATA_WIDTH(DATA_WIDTH)) u_realign (
    .clk(clk), .rst(rst),
    .s_axis_tdata(s_axis_tdata), .s_axis_tkeep(s_axis_tkeep),
    .s_axis_tvalid(s_axis_tvalid), .s_axis_tlast(s_axis_tlast),
    .s_axis_tready(s_axis_tready),
    .base_offset(wr_base_addr[MASK_BITS-1:0]), .desc_block(desc_block),
    .beat(beat_bus.src), .start(start), .mem_wr_data(mem_wr_data)
  );

  wr_addr_count #(.DATA_WIDTH(DATA_WIDTH)) u_addr_count (
    .clk(clk), .rst(rst), .start(start), .wr_base_addr(wr_base_addr),
    .beat(beat_bus.addr), .strb(beat_bus.strb), .mem_wr_addr(mem_wr_addr),
    .start_addr(start_addr), .next_len(next_len)
  );

  recv_desc_reg u_desc_reg (
    .clk(clk), .rst(rst), .start(start),
    .s_axis_tdest(s_axis_tdest), .s_axis_tuser(s_axis_tuser),
    .beat(beat_bus.desc), .next_len(next_len), .start_addr(start_addr),
    .recv_desc_ready(recv_desc_ready), .recv_desc_valid(recv_desc_valid),
    .recv_desc_addr(recv_desc_addr), .recv_desc_len(recv_desc_len),
    .recv_desc_tdest(recv_desc_tdest), .recv_desc_tuser(recv_desc_tuser),
    .desc_block(desc_block)
  );

endmodule

// File: logic/recv_desc_reg.sv
module recv_desc_reg (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  dma_pkg::dest_t  s_axis_tdest,
  input  dma_pkg::user_t  s_axis_tuser,
  wr_beat_if.desc         beat,
  input  dma_pkg::len_t   next_len,
  input  dma_pkg::addr_t  start_addr,
  input  logic            recv_desc_ready,
  output logic            recv_desc_valid,
  output dma_pkg::addr_t  recv_desc_addr,
  output dma_pkg::len_t   recv_desc_len,
  output dma_pkg::dest_t  recv_desc_tdest,
  output dma_pkg::user_t  recv_desc_tuser,
  output logic            desc_block
);

  import dma_pkg::*;

  dest_t pkt_tdest;
  user_t pkt_tuser;
  addr_t pend_addr;
  len_t  pend_len;
  dest_t pend_tdest;
  user_t pend_tuser;
  logic  late;
  logic  last_taken;
  logic  load_now;
  logic  load_late;

  assign last_taken = beat.en && beat.ready && beat.last;
  assign desc_block = recv_desc_valid && !recv_desc_ready;
  assign load_now   = last_taken && !desc_block;
  assign load_late  = late && recv_desc_ready;

  // Sideband tags belong to the first word of the packet
  always_ff @(posedge clk) begin
    if (start) begin
      pkt_tdest <= s_axis_tdest;
      pkt_tuser <= s_axis_tuser;
    end
  end

  //////////////////////////////////////////////////
  // Late descriptor held while the output is busy
  //////////////////////////////////////////////////

  // Snapshot everything now, the next packet may already be overwriting
  // the live address and tags
  always_ff @(posedge clk) begin
    if (last_taken && desc_block) begin
      pend_addr  <= start_addr;
      pend_len   <= next_len;
      pend_tdest <= pkt_tdest;
      pend_tuser <= pkt_tuser;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      late <= 1'b0;
    end else if (last_taken && desc_block) begin
      late <= 1'b1;
    end else if (recv_desc_ready) begin
      late <= 1'b0;
    end
  end

  // Older pending descriptor goes first to keep packet order
  always_ff @(posedge clk) begin
    if (load_late) begin
      recv_desc_addr  <= pend_addr;
      recv_desc_len   <= pend_len;
      recv_desc_tdest <= pend_tdest;
      recv_desc_tuser <= pend_tuser;
    end else if (load_now) begin
      recv_desc_addr  <= start_addr;
      recv_desc_len   <= next_len;
      recv_desc_tdest <= pkt_tdest;
      recv_desc_tuser <= pkt_tuser;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      recv_desc_valid <= 1'b0;
    end else if (load_now || load_late) begin
      recv_desc_valid <= 1'b1;
    end else if (recv_desc_ready) begin
      recv_desc_valid <= 1'b0;
    end
  end

endmodule

// File: logic/wr_addr_count.sv
module wr_addr_count #(
  parameter int DATA_WIDTH = 64
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  dma_pkg::addr_t          wr_base_addr,
  wr_beat_if.addr                 beat,
  input  logic [DATA_WIDTH/8-1:0] strb,
  output dma_pkg::addr_t          mem_wr_addr,
  output dma_pkg::addr_t          start_addr,
  output dma_pkg::len_t           next_len
);

  import dma_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int MASK_BITS  = $clog2(STRB_WIDTH);

  addr_t start_addr_r;
  addr_t aligned_addr;
  addr_t next_addr_r;
  len_t  len_r;
  len_t  beat_bytes;
  logic  take;

  assign take = beat.en && beat.ready;

  //////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////

  // Byte base of the packet, also reported in the descriptor
  always_ff @(posedge clk) begin
    if (rst) begin
      start_addr_r <= '0;
    end else if (start) begin
      start_addr_r <= wr_base_addr;
    end
  end

  // Memory beats always land on word boundaries
  assign aligned_addr = {start_addr_r[ADDR_WIDTH-1:MASK_BITS], {MASK_BITS{1'b0}}};

  // Advance one word for every beat the memory takes
  always_ff @(posedge clk) begin
    if (take) begin
      next_addr_r <= mem_wr_addr + addr_t'(STRB_WIDTH);
    end
  end

  assign mem_wr_addr = beat.first ? aligned_addr : next_addr_r;
  assign start_addr  = start_addr_r;

  //////////////////////////////////////////////////
  // Byte count
  //////////////////////////////////////////////////

  // Strobes may have holes, so count every lane
  always_comb begin
    beat_bytes = '0;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      beat_bytes = beat_bytes + len_t'(strb[i]);
    end
  end

  // Length including the beat now on the port, restarting with a new packet
  assign next_len = beat.first ? beat_bytes : len_r + beat_bytes;

  always_ff @(posedge clk) begin
    if (take) begin
      len_r <= next_len;
    end
  end

endmodule

// File: logic/wr_realign.sv
module wr_realign #(
  parameter int DATA_WIDTH = 64
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [DATA_WIDTH-1:0]             s_axis_tdata,
  input  logic [DATA_WIDTH/8-1:0]           s_axis_tkeep,
  input  logic                              s_axis_tvalid,
  input  logic                              s_axis_tlast,
  output logic                              s_axis_tready,
  input  logic [$clog2(DATA_WIDTH/8)-1:0]   base_offset,
  input  logic                              desc_block,
  wr_beat_if.src                            beat,
  output logic                              start,
  output logic [DATA_WIDTH-1:0]             mem_wr_data
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int MASK_BITS  = $clog2(STRB_WIDTH);
  localparam logic [MASK_BITS:0] WORD_BYTES = (MASK_BITS + 1)'(STRB_WIDTH);

  logic                    in_pkt;
  logic [MASK_BITS:0]      offset_r;
  logic [MASK_BITS:0]      start_offset;
  logic                    strb_left;
  logic [DATA_WIDTH-1:0]   data_1;
  logic [DATA_WIDTH-1:0]   data_2;
  logic [STRB_WIDTH-1:0]   strb_1;
  logic [STRB_WIDTH-1:0]   strb_2;
  logic                    last_1;
  logic                    wr_en_r;
  logic                    extra_r;
  logic                    first_r;
  logic                    accept;
  logic                    take;
  logic                    extra_beat;
  logic                    last_beat;
  logic [2*DATA_WIDTH-1:0] word_pair;
  logic [2*STRB_WIDTH-1:0] strb_pair;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  assign accept = s_axis_tvalid && s_axis_tready;
  assign take   = wr_en_r && beat.ready;

  // The last input word still has bytes past the word it shifts into
  assign extra_beat = last_1 && strb_left;

  // With a tail overflow the inserted beat is the final one instead
  assign last_beat = wr_en_r && ((last_1 && !extra_beat) || extra_r);

  // A new packet starts when idle or right as the previous one drains
  assign start = accept && (!in_pkt || (last_beat && beat.ready));

  // Hold off input during the tail beat, and keep the next packet's
  // last word out while the previous descriptor is still waiting
  assign s_axis_tready = beat.ready && !extra_beat && !(s_axis_tlast && desc_block);

  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt <= 1'b0;
    end else if (accept) begin
      in_pkt <= 1'b1;
    end else if (last_beat && beat.ready) begin
      in_pkt <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Offset and tail tracking
  //////////////////////////////////////////////////

  // Bytes of the first word that fit before the next word boundary
  assign start_offset = WORD_BYTES - {1'b0, base_offset};

  always_ff @(posedge clk) begin
    if (rst) begin
      offset_r <= WORD_BYTES;
    end else if (start) begin
      offset_r <= start_offset;
    end
  end

  // Look ahead at each accepted word for bytes spilling past the shift
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_left <= 1'b0;
    end else if (extra_beat && take) begin
      strb_left <= 1'b0;
    end else if (start) begin
      strb_left <= |(s_axis_tkeep >> start_offset);
    end else if (accept) begin
      strb_left <= |(s_axis_tkeep >> offset_r);
    end
  end

  //////////////////////////////////////////////////
  // Two-stage word pipeline
  //////////////////////////////////////////////////

  // First stage empties itself once the tail beat goes out
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_1 <= '0;
      last_1 <= 1'b0;
    end else if (extra_beat && take) begin
      strb_1 <= '0;
      last_1 <= 1'b0;
    end else if (accept) begin
      strb_1 <= s_axis_tkeep;
      last_1 <= s_axis_tlast;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      data_1 <= s_axis_tdata;
    end
    if (take) begin
      data_2 <= data_1;
    end
  end

  // Second stage strobes clear at packet end so the next first word
  // shifts in against empty lanes
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_2  <= '0;
      extra_r <= 1'b0;
    end else begin
      if (last_beat && beat.ready) begin
        strb_2 <= '0;
      end else if (take) begin
        strb_2 <= strb_1;
      end
      if (take) begin
        extra_r <= extra_beat;
      end
    end
  end

  // Enable stays up while stalled and for one more cycle on a tail beat
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en_r <= 1'b0;
      first_r <= 1'b0;
    end else begin
      wr_en_r <= accept || (wr_en_r && (extra_beat || !beat.ready));
      first_r <= start || (first_r && !beat.ready);
    end
  end

  // Shift the stage pair right so packet byte 0 lands at its offset
  assign word_pair   = {data_1, data_2} >> {offset_r, 3'b000};
  assign strb_pair   = {strb_1, strb_2} >> offset_r;
  assign mem_wr_data = word_pair[DATA_WIDTH-1:0];

  assign beat.en    = wr_en_r;
  assign beat.strb  = strb_pair[STRB_WIDTH-1:0];
  assign beat.last  = last_beat;
  assign beat.first = first_r;

endmodule

// File: logic/wr_beat_if.sv
// Control side of one aligned memory write beat
interface wr_beat_if #(
  parameter int STRB_WIDTH = 8
) ();

  // A beat is presented on the memory write port
  logic                  en;
  // Byte strobes after realignment
  logic [STRB_WIDTH-1:0] strb;
  // Final beat of the packet, including an inserted tail beat
  logic                  last;
  // Beat that carries the start of the packet
  logic                  first;
  // Memory accepts the beat, taken when en is high too
  logic                  ready;

  // The realigner produces the beat
  modport src (output en, output strb, output last, output first, input ready);

  // Address generation steps on every taken beat
  modport addr (input en, input first, input ready);

  // Descriptor capture watches for the final taken beat
  modport desc (input strb, input en, input last, input ready);

endinterface

// File: logic/dma_pkg.sv
package dma_pkg;

  //////////////////////////////////////////////////
  // Widths shared by the write DMA blocks
  //////////////////////////////////////////////////

  // Byte address into the packet memory
  localparam int ADDR_WIDTH = 16;

  // Packet length in bytes, wide enough for the largest buffer
  localparam int LEN_WIDTH  = 16;

  // Stream sideband tags carried into the receive descriptor
  localparam int DEST_WIDTH = 8;
  localparam int USER_WIDTH = 2;

  // Scalar types used on ports and inside the blocks
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [LEN_WIDTH-1:0]  len_t;
  typedef logic [DEST_WIDTH-1:0] dest_t;
  typedef logic [USER_WIDTH-1:0] user_t;

endpackage
